//--- rtl/harness_pkg.sv
// ------------------------------
// Harness shared definitions
// Widths, address map, latencies
// ------------------------------
`default_nettype none

package harness_pkg;

  // Bus widths
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int WORD_IDX_W = 10;

  // Slow memory
  localparam int MEM_WORDS  = 1024;
  localparam int MEM_WAIT   = 3;
  localparam int WAIT_CNT_W = $clog2(MEM_WAIT + 1);

  // Power domains are CPU, peripheral and external
  localparam int SWITCH_ACK_LATENCY = 15;
  localparam int NUM_DOMAINS        = 3;

  // Interrupt lines
  localparam int NUM_INTR   = 3;
  localparam int INTR_MEM   = 0;
  localparam int INTR_POWER = 1;
  localparam int INTR_SW    = 2;

  // Address map, top nibble selects the region
  localparam logic [3:0] REGION_MEM  = 4'd1;
  localparam logic [3:0] REGION_CTRL = 4'd2;

  // Control register word offsets
  localparam int CTRL_PENDING = 0;
  localparam int CTRL_ENABLE  = 1;
  localparam int CTRL_SW_SET  = 2;
  localparam int CTRL_POWER   = 3;

  // Bus FSM state codes
  localparam logic [1:0] FSM_IDLE   = 2'd0;
  localparam logic [1:0] FSM_DECODE = 2'd1;
  localparam logic [1:0] FSM_WAIT   = 2'd2;

  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [3:0]            region;
      logic [15:0]           unused;
      logic [WORD_IDX_W-1:0] word_idx;
      logic [1:0]            byte_off;
    } f;
  } bus_addr_u;

endpackage

`default_nettype wire

//--- rtl/reg_bus_if.sv
// ------------------------------
// Register bus link
// One request and its response
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;

  logic                               req;
  logic                               we;
  logic [harness_pkg::WORD_IDX_W-1:0] word_idx;
  logic [harness_pkg::DATA_W-1:0]     wdata;
  logic                               rsp_valid;
  logic [harness_pkg::DATA_W-1:0]     rdata;
  // Error flag follows the FSM response, devices never drive it
  logic                               error;

  modport host (
    output req,
    output we,
    output word_idx,
    output wdata,
    output error,
    input  rsp_valid,
    input  rdata
  );

  modport device (
    input  req,
    input  we,
    input  word_idx,
    input  wdata,
    output rsp_valid,
    output rdata
  );

endinterface

`default_nettype wire

//--- rtl/wait_timer.sv
// ------------------------------
// Wait timer for slow accesses
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module wait_timer (
  input  wire  clk_i,
  input  wire  rst_i,
  input  wire  start_i,
  output logic busy_o,
  output logic done_o
);

  logic [harness_pkg::WAIT_CNT_W-1:0] cnt_q;
  logic                               done_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        cnt_q <= harness_pkg::MEM_WAIT[harness_pkg::WAIT_CNT_W-1:0];
      end else if (cnt_q != '0) begin
        cnt_q  <= cnt_q - 1'b1;
        // Last step of the count
        done_q <= (cnt_q == 1);
      end
    end
  end

  assign busy_o = (cnt_q != '0);
  assign done_o = done_q;

endmodule

`default_nettype wire

//--- rtl/slow_memory.sv
// ------------------------------
// Slow word memory
// Answers after a fixed wait
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module slow_memory (
  input  wire         clk_i,
  input  wire         rst_i,
  reg_bus_if.device   bus,
  output logic        access_done_o
);

  logic [harness_pkg::DATA_W-1:0]     mem [harness_pkg::MEM_WORDS];
  logic [harness_pkg::WORD_IDX_W-1:0] idx_q;
  logic                               we_q;
  logic [harness_pkg::DATA_W-1:0]     wdata_q;
  logic                               start;
  logic                               timer_busy;
  logic                               timer_done;

  assign start = bus.req && !timer_busy;

  // Access is held until the timer runs out
  always_ff @(posedge clk_i) begin
    if (start) begin
      idx_q   <= bus.word_idx;
      we_q    <= bus.we;
      wdata_q <= bus.wdata;
    end
  end

  wait_timer u_wait_timer (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (start),
    .busy_o  (timer_busy),
    .done_o  (timer_done)
  );

  always_ff @(posedge clk_i) begin
    if (timer_done && we_q) begin
      mem[idx_q] <= wdata_q;
    end
  end

  // Response in the done cycle, writes return zero
  assign bus.rsp_valid  = timer_done;
  assign bus.rdata      = (timer_done && !we_q) ? mem[idx_q] : '0;
  assign access_done_o  = timer_done;

endmodule

`default_nettype wire

//--- rtl/ctrl_regs.sv
// ------------------------------
// Control registers
// Interrupt pending/enable and power status
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
  input  wire                                  clk_i,
  input  wire                                  rst_i,
  reg_bus_if.device                            bus,
  input  wire                                  access_done_i,
  input  wire [harness_pkg::NUM_DOMAINS-1:0]   switch_ack_n_i,
  output logic [harness_pkg::NUM_INTR-1:0]     intr_o
);

  logic [harness_pkg::NUM_INTR-1:0]    pending_q;
  logic [harness_pkg::NUM_INTR-1:0]    enable_q;
  logic [harness_pkg::NUM_INTR-1:0]    set_bits;
  logic [harness_pkg::NUM_INTR-1:0]    clr_bits;
  logic [harness_pkg::NUM_DOMAINS-1:0] ack_prev_q;
  logic                                power_change;
  logic                                wr_pending;
  logic                                wr_enable;
  logic                                wr_sw_set;
  logic                                rsp_valid_q;
  logic [harness_pkg::DATA_W-1:0]      rdata_q;

  assign wr_pending   = bus.req && bus.we && (bus.word_idx == harness_pkg::CTRL_PENDING);
  assign wr_enable    = bus.req && bus.we && (bus.word_idx == harness_pkg::CTRL_ENABLE);
  assign wr_sw_set    = bus.req && bus.we && (bus.word_idx == harness_pkg::CTRL_SW_SET);
  assign power_change = |(ack_prev_q ^ switch_ack_n_i);

  // Set events win over a clear in the same cycle
  always_comb begin
    set_bits = '0;
    if (wr_sw_set) begin
      set_bits = bus.wdata[harness_pkg::NUM_INTR-1:0];
    end
    set_bits[harness_pkg::INTR_MEM]   = set_bits[harness_pkg::INTR_MEM] | access_done_i;
    set_bits[harness_pkg::INTR_POWER] = set_bits[harness_pkg::INTR_POWER] | power_change;
    clr_bits = wr_pending ? bus.wdata[harness_pkg::NUM_INTR-1:0] : '0;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q   <= '0;
      enable_q    <= '0;
      ack_prev_q  <= '1;
      rsp_valid_q <= 1'b0;
    end else begin
      pending_q   <= (pending_q & ~clr_bits) | set_bits;
      ack_prev_q  <= switch_ack_n_i;
      rsp_valid_q <= bus.req;
      if (wr_enable) begin
        enable_q <= bus.wdata[harness_pkg::NUM_INTR-1:0];
      end
    end
  end

  // Read data, one cycle after the request
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= '0;
      if (!bus.we) begin
        case (bus.word_idx)
          harness_pkg::CTRL_PENDING: rdata_q[harness_pkg::NUM_INTR-1:0] <= pending_q;
          harness_pkg::CTRL_ENABLE:  rdata_q[harness_pkg::NUM_INTR-1:0] <= enable_q;
          harness_pkg::CTRL_POWER:   rdata_q[harness_pkg::NUM_DOMAINS-1:0] <= switch_ack_n_i;
          default:                   rdata_q <= '0;
        endcase
      end
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rdata     = rdata_q;
  assign intr_o        = pending_q & enable_q;

endmodule

`default_nettype wire

//--- rtl/power_switch_emu.sv
// ------------------------------
// Power switch emulator
// Delayed acknowledge per domain
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module power_switch_emu (
  input  wire                                 clk_i,
  input  wire                                 rst_i,
  input  wire [harness_pkg::NUM_DOMAINS-1:0]  switch_n_i,
  output logic [harness_pkg::NUM_DOMAINS-1:0] switch_ack_n_o
);

  logic [harness_pkg::NUM_DOMAINS-1:0] stage_q [harness_pkg::SWITCH_ACK_LATENCY];

  // Switches are active low, so the idle level is all ones
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < harness_pkg::SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < harness_pkg::SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = stage_q[harness_pkg::SWITCH_ACK_LATENCY-1];

endmodule

`default_nettype wire

//--- rtl/bus_fsm.sv
// ------------------------------
// Host bus FSM
// Latches a request, decodes the region, routes it
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_fsm (
  input  wire                                 clk_i,
  input  wire                                 rst_i,
  input  wire                                 req_valid_i,
  input  wire                                 req_we_i,
  input  wire harness_pkg::bus_addr_u         req_addr_i,
  input  wire [harness_pkg::DATA_W-1:0]       req_wdata_i,
  output logic                                rsp_valid_o,
  output logic [harness_pkg::DATA_W-1:0]      rsp_rdata_o,
  output logic                                rsp_error_o,
  reg_bus_if.host                             mem_bus,
  reg_bus_if.host                             ctrl_bus
);

  logic [1:0]                     state_q;
  harness_pkg::bus_addr_u         addr_q;
  logic                           we_q;
  logic [harness_pkg::DATA_W-1:0] wdata_q;
  logic                           is_mem;
  logic                           is_ctrl;
  logic                           unmapped_rsp;
  logic                           dev_rsp_valid;
  logic [harness_pkg::DATA_W-1:0] dev_rdata;

  // Region decode on the latched address
  assign is_mem       = (addr_q.f.region == harness_pkg::REGION_MEM);
  assign is_ctrl      = (addr_q.f.region == harness_pkg::REGION_CTRL);
  assign unmapped_rsp = (state_q == harness_pkg::FSM_DECODE) && !is_mem && !is_ctrl;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= harness_pkg::FSM_IDLE;
    end else begin
      case (state_q)
        harness_pkg::FSM_IDLE: begin
          if (req_valid_i) begin
            state_q <= harness_pkg::FSM_DECODE;
          end
        end
        harness_pkg::FSM_DECODE: begin
          state_q <= (is_mem || is_ctrl) ? harness_pkg::FSM_WAIT : harness_pkg::FSM_IDLE;
        end
        harness_pkg::FSM_WAIT: begin
          if (dev_rsp_valid) begin
            state_q <= harness_pkg::FSM_IDLE;
          end
        end
        default: begin
          state_q <= harness_pkg::FSM_IDLE;
        end
      endcase
    end
  end

  // Strobes outside idle are dropped
  always_ff @(posedge clk_i) begin
    if ((state_q == harness_pkg::FSM_IDLE) && req_valid_i) begin
      addr_q.raw <= req_addr_i.raw;
      we_q       <= req_we_i;
      wdata_q    <= req_wdata_i;
    end
  end

  // ------------------------------
  // Device side
  // ------------------------------
  assign mem_bus.req       = (state_q == harness_pkg::FSM_DECODE) && is_mem;
  assign mem_bus.we        = we_q;
  assign mem_bus.word_idx  = addr_q.f.word_idx;
  assign mem_bus.wdata     = wdata_q;
  assign mem_bus.error     = unmapped_rsp;

  assign ctrl_bus.req      = (state_q == harness_pkg::FSM_DECODE) && is_ctrl;
  assign ctrl_bus.we       = we_q;
  assign ctrl_bus.word_idx = addr_q.f.word_idx;
  assign ctrl_bus.wdata    = wdata_q;
  assign ctrl_bus.error    = unmapped_rsp;

  always_comb begin
    dev_rsp_valid = 1'b0;
    dev_rdata     = '0;
    if (state_q == harness_pkg::FSM_WAIT) begin
      if (is_mem) begin
        dev_rsp_valid = mem_bus.rsp_valid;
        dev_rdata     = mem_bus.rdata;
      end else if (is_ctrl) begin
        dev_rsp_valid = ctrl_bus.rsp_valid;
        dev_rdata     = ctrl_bus.rdata;
      end
    end
  end

  // Host response, unmapped accesses answer from decode
  assign rsp_valid_o = dev_rsp_valid || unmapped_rsp;
  assign rsp_rdata_o = dev_rsp_valid ? dev_rdata : '0;
  assign rsp_error_o = unmapped_rsp;

endmodule

`default_nettype wire

//--- rtl/periph_harness_top.sv
// ------------------------------
// Peripheral harness top level
// Bus, memory, registers, power emulator
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module periph_harness_top (
  input  wire                                 clk_i,
  input  wire                                 rst_i,
  input  wire                                 req_valid_i,
  input  wire                                 req_we_i,
  input  wire [harness_pkg::ADDR_W-1:0]       req_addr_i,
  input  wire [harness_pkg::DATA_W-1:0]       req_wdata_i,
  output logic                                rsp_valid_o,
  output logic [harness_pkg::DATA_W-1:0]      rsp_rdata_o,
  output logic                                rsp_error_o,
  input  wire [harness_pkg::NUM_DOMAINS-1:0]  switch_n_i,
  output logic [harness_pkg::NUM_DOMAINS-1:0] switch_ack_n_o,
  output logic [harness_pkg::NUM_INTR-1:0]    intr_o
);

  logic access_done;

  reg_bus_if mem_bus ();
  reg_bus_if ctrl_bus ();

  bus_fsm u_bus_fsm (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_error_o (rsp_error_o),
    .mem_bus     (mem_bus),
    .ctrl_bus    (ctrl_bus)
  );

  slow_memory u_slow_memory (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .bus           (mem_bus),
    .access_done_o (access_done)
  );

  ctrl_regs u_ctrl_regs (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .bus            (ctrl_bus),
    .access_done_i  (access_done),
    .switch_ack_n_i (switch_ack_n_o),
    .intr_o         (intr_o)
  );

  power_switch_emu u_power_switch_emu (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .switch_n_i     (switch_n_i),
    .switch_ack_n_o (switch_ack_n_o)
  );

endmodule

`default_nettype wire

//--- verification/harness_checker.sv
// ------------------------------
// Harness response checker
// Compares responses, interrupts and power acknowledge
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module harness_checker (
  input  wire                                clk_i,
  input  wire                                rst_i,
  input  wire                                rsp_valid_i,
  input  wire [harness_pkg::DATA_W-1:0]      rsp_rdata_i,
  input  wire                                rsp_error_i,
  input  wire [harness_pkg::NUM_DOMAINS-1:0] switch_n_i,
  input  wire [harness_pkg::NUM_DOMAINS-1:0] switch_ack_n_i,
  input  wire [harness_pkg::NUM_INTR-1:0]    intr_i,
  input  wire                                exp_push_i,
  input  wire [harness_pkg::DATA_W-1:0]      exp_rdata_i,
  input  wire                                exp_error_i,
  input  wire                                intr_chk_i,
  input  wire [harness_pkg::NUM_INTR-1:0]    exp_intr_i,
  output int                                 rsp_cnt_o,
  output int                                 err_cnt_o,
  output int                                 missing_o
);

  logic [harness_pkg::DATA_W:0]        exp_q [$];
  logic [harness_pkg::NUM_DOMAINS-1:0] switch_hist [$];
  logic [harness_pkg::DATA_W:0]        expected;
  int                                  pushed      = 0;
  int                                  rsp_seen    = 0;
  int                                  rsp_errors  = 0;
  int                                  side_errors = 0;

  assign rsp_cnt_o = rsp_seen;
  assign err_cnt_o = rsp_errors + side_errors;
  assign missing_o = pushed - rsp_seen;

  // Expectations, acknowledge delay and interrupt checks on the rising edge
  always @(posedge clk_i) begin
    if (exp_push_i) begin
      exp_q.push_back({exp_error_i, exp_rdata_i});
      pushed++;
    end
    if (rst_i) begin
      switch_hist.delete();
      for (int i = 0; i < harness_pkg::SWITCH_ACK_LATENCY; i++) begin
        switch_hist.push_back('1);
      end
    end else begin
      if (switch_ack_n_i !== switch_hist[0]) begin
        $display("Error @%0t: switch ack %b, expected %b", $time, switch_ack_n_i,
                 switch_hist[0]);
        side_errors++;
      end
      void'(switch_hist.pop_front());
      switch_hist.push_back(switch_n_i);
    end
    if (intr_chk_i && (intr_i !== exp_intr_i)) begin
      $display("Error @%0t: intr %b, expected %b", $time, intr_i, exp_intr_i);
      side_errors++;
    end
  end

  // Response is stable around the falling edge
  always @(negedge clk_i) begin
    if (rsp_valid_i) begin
      if (exp_q.size() == 0) begin
        $display("Error @%0t: response arrived with no request outstanding", $time);
        rsp_errors++;
      end else begin
        expected = exp_q.pop_front();
        rsp_seen++;
        if ((rsp_error_i !== expected[harness_pkg::DATA_W]) ||
            (rsp_rdata_i !== expected[harness_pkg::DATA_W-1:0])) begin
          $display("Error @%0t: rdata %h error %b, expected rdata %h error %b", $time,
                   rsp_rdata_i, rsp_error_i, expected[harness_pkg::DATA_W-1:0],
                   expected[harness_pkg::DATA_W]);
          rsp_errors++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/harness_asserts.sv
// ------------------------------
// Bus and power assertions
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module harness_asserts (
  input wire                                clk_i,
  input wire                                rst_i,
  input wire                                strobe_i,
  input wire                                pulse_i,
  input wire                                flag_i,
  input wire [harness_pkg::NUM_DOMAINS-1:0] din_i,
  input wire [harness_pkg::NUM_DOMAINS-1:0] dout_i
);

  int since_rst = 0;
  int fail_cnt  = 0;

  always @(posedge clk_i) begin
    if (rst_i) begin
      since_rst <= 0;
    end else if (since_rst < harness_pkg::SWITCH_ACK_LATENCY) begin
      since_rst <= since_rst + 1;
    end
  end

  pulse_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    pulse_i |=> !pulse_i)
    else begin
      fail_cnt++;
      $error("response strobe held longer than one cycle");
    end

  // Unmapped accesses answer in the cycle after the request strobe
  flag_with_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    flag_i |-> (pulse_i && $past(strobe_i)))
    else begin
      fail_cnt++;
      $error("error flag raised without a response one cycle after a request");
    end

  // Idle acknowledge until the first switch value has passed through
  ack_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    (since_rst < harness_pkg::SWITCH_ACK_LATENCY) |-> (dout_i == '1))
    else begin
      fail_cnt++;
      $error("acknowledge left idle level too early");
    end

  ack_delay: assert property (@(posedge clk_i) disable iff (rst_i)
    (since_rst == harness_pkg::SWITCH_ACK_LATENCY) |->
      (dout_i == $past(din_i, harness_pkg::SWITCH_ACK_LATENCY)))
    else begin
      fail_cnt++;
      $error("acknowledge does not match the delayed switch request");
    end

endmodule

bind bus_fsm harness_asserts u_fsm_asserts (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .strobe_i (req_valid_i),
  .pulse_i  (rsp_valid_o),
  .flag_i   (rsp_error_o),
  .din_i    ('1),
  .dout_i   ('1)
);

bind power_switch_emu harness_asserts u_pwr_asserts (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .strobe_i (1'b0),
  .pulse_i  (1'b0),
  .flag_i   (1'b0),
  .din_i    (switch_n_i),
  .dout_i   (switch_ack_n_o)
);

`default_nettype wire

//--- verification/tb_periph_harness.sv
// ------------------------------
// Peripheral harness testbench
// Memory, control registers, power and unmapped accesses
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_periph_harness;

  localparam int NUM_TXN        = 50;
  localparam int TIMEOUT_CYCLES = 40 * NUM_TXN + 200;

  logic                                clk_i;
  logic                                rst_i;
  logic                                req_valid;
  logic                                req_we;
  logic [harness_pkg::ADDR_W-1:0]      req_addr;
  logic [harness_pkg::DATA_W-1:0]      req_wdata;
  logic                                rsp_valid;
  logic [harness_pkg::DATA_W-1:0]      rsp_rdata;
  logic                                rsp_error;
  logic [harness_pkg::NUM_DOMAINS-1:0] switch_n;
  logic [harness_pkg::NUM_DOMAINS-1:0] switch_ack_n;
  logic [harness_pkg::NUM_INTR-1:0]    intr;
  logic                                exp_push;
  logic [harness_pkg::DATA_W-1:0]      exp_rdata;
  logic                                exp_error;
  logic                                intr_chk;
  logic [harness_pkg::NUM_INTR-1:0]    exp_intr;
  int                                  rsp_cnt;
  int                                  err_cnt;
  int                                  missing;
  int                                  cycle_cnt = 0;
  bit                                  timed_out = 1'b0;
  integer                              seed;
  logic [3:0]                          bad_regions [4] = '{4'd0, 4'd3, 4'd9, 4'd15};

  // Reference state
  logic [harness_pkg::DATA_W-1:0]      model_mem [int];
  logic [harness_pkg::NUM_INTR-1:0]    model_pending;
  logic [harness_pkg::NUM_INTR-1:0]    model_enable;
  logic [harness_pkg::NUM_DOMAINS-1:0] model_power;

  periph_harness_top uut (
    .clk_i (clk_i), .rst_i (rst_i),
    .req_valid_i (req_valid), .req_we_i (req_we),
    .req_addr_i (req_addr), .req_wdata_i (req_wdata),
    .rsp_valid_o (rsp_valid), .rsp_rdata_o (rsp_rdata), .rsp_error_o (rsp_error),
    .switch_n_i (switch_n), .switch_ack_n_o (switch_ack_n), .intr_o (intr)
  );

  harness_checker u_checker (
    .clk_i (clk_i), .rst_i (rst_i),
    .rsp_valid_i (rsp_valid), .rsp_rdata_i (rsp_rdata), .rsp_error_i (rsp_error),
    .switch_n_i (switch_n), .switch_ack_n_i (switch_ack_n), .intr_i (intr),
    .exp_push_i (exp_push), .exp_rdata_i (exp_rdata), .exp_error_i (exp_error),
    .intr_chk_i (intr_chk), .exp_intr_i (exp_intr),
    .rsp_cnt_o (rsp_cnt), .err_cnt_o (err_cnt), .missing_o (missing)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Expected {error, rdata} from the address map and the model state
  function automatic logic [harness_pkg::DATA_W:0] expected_rsp(
    input logic we, input harness_pkg::bus_addr_u addr);
    logic [harness_pkg::DATA_W:0] rsp;
    rsp = '0;
    if (addr.f.region == harness_pkg::REGION_MEM) begin
      if (!we) begin
        rsp[harness_pkg::DATA_W-1:0] = model_mem[int'(addr.f.word_idx)];
      end
    end else if (addr.f.region == harness_pkg::REGION_CTRL) begin
      if (!we) begin
        case (int'(addr.f.word_idx))
          harness_pkg::CTRL_PENDING: rsp[harness_pkg::NUM_INTR-1:0] = model_pending;
          harness_pkg::CTRL_ENABLE:  rsp[harness_pkg::NUM_INTR-1:0] = model_enable;
          harness_pkg::CTRL_POWER:   rsp[harness_pkg::NUM_DOMAINS-1:0] = model_power;
          default: ;
        endcase
      end
    end else begin
      rsp[harness_pkg::DATA_W] = 1'b1;
    end
    return rsp;
  endfunction

  task automatic update_model(input logic we, input harness_pkg::bus_addr_u addr,
                              input logic [harness_pkg::DATA_W-1:0] wdata);
    if (addr.f.region == harness_pkg::REGION_MEM) begin
      if (we) begin
        model_mem[int'(addr.f.word_idx)] = wdata;
      end
      model_pending[harness_pkg::INTR_MEM] = 1'b1;
    end else if ((addr.f.region == harness_pkg::REGION_CTRL) && we) begin
      case (int'(addr.f.word_idx))
        harness_pkg::CTRL_PENDING: model_pending &= ~wdata[harness_pkg::NUM_INTR-1:0];
        harness_pkg::CTRL_ENABLE:  model_enable = wdata[harness_pkg::NUM_INTR-1:0];
        harness_pkg::CTRL_SW_SET:  model_pending |= wdata[harness_pkg::NUM_INTR-1:0];
        default: ;
      endcase
    end
  endtask

  task automatic bus_access(input logic we, input logic [3:0] region, input int idx,
                            input logic [harness_pkg::DATA_W-1:0] wdata);
    harness_pkg::bus_addr_u      addr;
    logic [harness_pkg::DATA_W:0] rsp;
    addr.raw        = $random(seed);
    addr.f.region   = region;
    addr.f.word_idx = idx[harness_pkg::WORD_IDX_W-1:0];
    rsp             = expected_rsp(we, addr);
    @(negedge clk_i);
    req_valid = 1'b1;
    req_we    = we;
    req_addr  = addr.raw;
    req_wdata = wdata;
    exp_push  = 1'b1;
    exp_rdata = rsp[harness_pkg::DATA_W-1:0];
    exp_error = rsp[harness_pkg::DATA_W];
    @(negedge clk_i);
    req_valid = 1'b0;
    exp_push  = 1'b0;
    while (!rsp_valid) begin
      @(negedge clk_i);
    end
    update_model(we, addr, wdata);
  endtask

  task automatic check_intr;
    @(negedge clk_i);
    intr_chk = 1'b1;
    exp_intr = model_pending & model_enable;
    @(negedge clk_i);
    intr_chk = 1'b0;
  endtask

  task automatic change_power(input logic [harness_pkg::NUM_DOMAINS-1:0] value);
    @(negedge clk_i);
    switch_n = value;
    repeat (harness_pkg::SWITCH_ACK_LATENCY + 3) @(negedge clk_i);
    if (value != model_power) begin
      model_pending[harness_pkg::INTR_POWER] = 1'b1;
    end
    model_power = value;
  endtask

  task automatic finish_run;
    $display("Responses checked: %0d, errors: %0d, assertion failures: %0d, missing: %0d",
             rsp_cnt, err_cnt, uut.u_bus_fsm.u_fsm_asserts.fail_cnt +
             uut.u_power_switch_emu.u_pwr_asserts.fail_cnt, missing);
    if (!timed_out && (err_cnt == 0) && (missing == 0) &&
        (uut.u_bus_fsm.u_fsm_asserts.fail_cnt == 0) &&
        (uut.u_power_switch_emu.u_pwr_asserts.fail_cnt == 0)) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    timed_out = 1'b1;
    $display("Timeout after %0d cycles, a response never arrived", cycle_cnt);
    finish_run();
  end

  initial begin
    seed          = 93868;
    rst_i         = 1'b1;
    req_valid     = 1'b0;
    req_we        = 1'b0;
    req_addr      = '0;
    req_wdata     = '0;
    switch_n      = '1;
    exp_push      = 1'b0;
    exp_rdata     = '0;
    exp_error     = 1'b0;
    intr_chk      = 1'b0;
    exp_intr      = '0;
    model_pending = '0;
    model_enable  = '0;
    model_power   = '1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_intr();

    // ------------------------------
    // Memory writes, then read back
    // ------------------------------
    for (int i = 0; i < 12; i++) begin
      bus_access(1'b1, harness_pkg::REGION_MEM, {$random(seed)} % 16, $random(seed));
    end
    for (int i = 0; i < 16; i++) begin
      if (model_mem.exists(i)) begin
        bus_access(1'b0, harness_pkg::REGION_MEM, i, $random(seed));
      end
    end
    check_intr();

    // Memory interrupt
    bus_access(1'b1, harness_pkg::REGION_CTRL, harness_pkg::CTRL_ENABLE, 32'h7);
    check_intr();
    bus_access(1'b0, harness_pkg::REGION_CTRL, harness_pkg::CTRL_PENDING, '0);
    bus_access(1'b1, harness_pkg::REGION_CTRL, harness_pkg::CTRL_PENDING, 32'h1);
    check_intr();
    bus_access(1'b1, harness_pkg::REGION_MEM, 1000, $random(seed));
    bus_access(1'b0, harness_pkg::REGION_MEM, 1000, '0);
    check_intr();
    bus_access(1'b1, harness_pkg::REGION_CTRL, harness_pkg::CTRL_PENDING, 32'h1);

    // Software interrupt, masked then enabled
    bus_access(1'b1, harness_pkg::REGION_CTRL, harness_pkg::CTRL_ENABLE, 32'h3);
    bus_access(1'b1, harness_pkg::REGION_CTRL, harness_pkg::CTRL_SW_SET, 32'h4);
    check_intr();
    bus_access(1'b1, harness_pkg::REGION_CTRL, harness_pkg::CTRL_ENABLE, 32'h7);
    check_intr();
    bus_access(1'b0, harness_pkg::REGION_CTRL, harness_pkg::CTRL_PENDING, '0);
    bus_access(1'b1, harness_pkg::REGION_CTRL, harness_pkg::CTRL_PENDING, 32'h7);
    check_intr();

    // ------------------------------
    // Power switch changes
    // ------------------------------
    change_power(3'b010);
    check_intr();
    bus_access(1'b0, harness_pkg::REGION_CTRL, harness_pkg::CTRL_POWER, '0);
    bus_access(1'b1, harness_pkg::REGION_CTRL, harness_pkg::CTRL_ENABLE, 32'h5);
    check_intr();
    change_power(3'b101);
    bus_access(1'b0, harness_pkg::REGION_CTRL, harness_pkg::CTRL_POWER, '0);
    bus_access(1'b1, harness_pkg::REGION_CTRL, harness_pkg::CTRL_ENABLE, 32'h7);
    check_intr();
    bus_access(1'b1, harness_pkg::REGION_CTRL, harness_pkg::CTRL_PENDING, 32'h7);
    check_intr();

    // Unmapped regions and offsets that read zero
    for (int i = 0; i < 4; i++) begin
      bus_access($random(seed) & 1, bad_regions[i], $random(seed), $random(seed));
    end
    bus_access(1'b0, harness_pkg::REGION_CTRL, harness_pkg::CTRL_SW_SET, '0);
    bus_access(1'b0, harness_pkg::REGION_CTRL, 77, '0);
    repeat (3) @(negedge clk_i);
    finish_run();
  end

endmodule

`default_nettype wire

//--- sim.f
rtl/harness_pkg.sv
rtl/reg_bus_if.sv
rtl/wait_timer.sv
rtl/slow_memory.sv
rtl/ctrl_regs.sv
rtl/power_switch_emu.sv
rtl/bus_fsm.sv
rtl/periph_harness_top.sv
verification/harness_checker.sv
verification/harness_asserts.sv
verification/tb_periph_harness.sv

//--- Bender.yml
package:
  name: periph_harness

sources:
  - rtl/harness_pkg.sv
  - rtl/reg_bus_if.sv
  - rtl/wait_timer.sv
  - rtl/slow_memory.sv
  - rtl/ctrl_regs.sv
  - rtl/power_switch_emu.sv
  - rtl/bus_fsm.sv
  - rtl/periph_harness_top.sv
  - target: test
    files:
      - verification/harness_checker.sv
      - verification/harness_asserts.sv
      - verification/tb_periph_harness.sv
